// File: i2c_master.f
hdl/i2c_pkg.sv
hdl/i2c_phase_timer.sv
hdl/i2c_byte_shifter.sv
hdl/i2c_bus_driver.sv
hdl/i2c_sequencer.sv
hdl/i2c_master.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --timescale 1ns/1ps
TOP       ?= tb_i2c_master
FILELIST  ?= i2c_master.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary -j 0 $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_i2c_master.sv
module tb_i2c_master import i2c_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [ADDR_BITS-1:0] OWN_ADDR = 7'h3a;
    localparam int NUM_RANDOM     = 60;
    localparam int NUM_DIRECTED   = 6;
    // Requests x bits per request x clocks per bit, doubled for margin
    localparam int TIMEOUT_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * 45 * 20 * 2;

    logic                 clk;
    logic                 rst_n;
    logic                 write_enable;
    logic                 read_enable;
    logic [ADDR_BITS-1:0] slave_address;
    logic [BYTE_BITS-1:0] rw_address;
    logic [BYTE_BITS-1:0] write_data;
    logic [BYTE_BITS-1:0] read_data;
    logic                 ready;
    logic                 ack_error;
    logic                 master_sda;
    logic                 master_scl;
    logic                 slave_sda;
    logic                 sda_bus;
    int                   start_count;
    int                   stop_count;
    logic [BYTE_BITS-1:0] ref_mem [256];
    logic [31:0]          lfsr_state;
    int                   errors;
    int                   checks;
    int                   cycles;

    // Open-drain bus with pull-up
    assign sda_bus = master_sda & slave_sda;

    i2c_master dut (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_write_enable(write_enable), .i_read_enable(read_enable),
        .i_slave_address(slave_address), .i_rw_address(rw_address),
        .i_write_data(write_data), .i_sda(sda_bus), .o_read_data(read_data),
        .o_ready(ready), .o_ack_error(ack_error), .o_sda(master_sda), .o_scl(master_scl)
    );

    i2c_slave_model #(.OWN_ADDR(OWN_ADDR)) u_slave (
        .i_scl(master_scl), .i_sda(sda_bus), .o_sda(slave_sda),
        .o_start_count(start_count), .o_stop_count(stop_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: master did not finish after %0d clock cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic wait_ready();
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic check_idle_lines(input int count);
        repeat (count) begin
            check_value(32'(ready), 32'd1, "o_ready while idle");
            check_value(32'({master_scl, master_sda}), 32'd3, "SCL and SDA while idle");
            @(negedge clk);
        end
    endtask

    task automatic run_request(input logic is_read, input logic both,
                               input logic [ADDR_BITS-1:0] address,
                               input logic [BYTE_BITS-1:0] reg_addr,
                               input logic [BYTE_BITS-1:0] data);
        int                   starts_before;
        int                   stops_before;
        int                   frames;
        logic                 acked;
        logic [BYTE_BITS-1:0] expected_read;
        wait_ready();
        check_value(32'({master_scl, master_sda}), 32'd3, "SCL and SDA before request");
        starts_before = start_count;
        stops_before  = stop_count;
        acked         = (address == OWN_ADDR);
        frames        = (is_read && acked) ? 2 : 1;
        expected_read = ref_mem[reg_addr];
        @(posedge clk);
        write_enable  <= !is_read || both;
        read_enable   <= is_read;
        slave_address <= address;
        rw_address    <= reg_addr;
        write_data    <= data;
        @(posedge clk);
        write_enable <= 1'b0;
        read_enable  <= 1'b0;
        @(negedge clk);
        check_value(32'(ready), 32'd0, "o_ready after accept");
        // Busy master has to drop this one
        repeat (8) @(posedge clk);
        write_enable  <= 1'b1;
        slave_address <= OWN_ADDR;
        rw_address    <= ~reg_addr;
        write_data    <= ~data;
        @(posedge clk);
        write_enable <= 1'b0;
        @(negedge clk);
        check_value(32'(ready), 32'd0, "o_ready during ignored request");
        wait_ready();
        check_value(32'(ack_error), 32'(!acked), "o_ack_error");
        if (is_read && acked) begin
            check_value(32'(read_data), 32'(expected_read), "o_read_data");
        end
        if (!is_read && acked) begin
            ref_mem[reg_addr] = data;
        end
        check_value(32'(u_slave.regs[reg_addr]), 32'(ref_mem[reg_addr]), "slave register");
        check_value(32'(u_slave.regs[~reg_addr]), 32'(ref_mem[~reg_addr]), "untouched register");
        check_value(32'(start_count - starts_before), 32'(frames), "start conditions");
        check_value(32'(stop_count - stops_before), 32'(frames), "stop conditions");
        check_value(32'({master_scl, master_sda}), 32'd3, "SCL and SDA after request");
    endtask

    initial begin
        logic                 is_read;
        logic                 both;
        logic [ADDR_BITS-1:0] address;
        logic [BYTE_BITS-1:0] reg_addr;
        logic [BYTE_BITS-1:0] data;
        errors        = 0;
        checks        = 0;
        lfsr_state    = 32'hd8ee_846d;
        rst_n         <= 1'b0;
        write_enable  <= 1'b0;
        read_enable   <= 1'b0;
        slave_address <= '0;
        rw_address    <= '0;
        write_data    <= '0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_value(32'({master_scl, master_sda}), 32'd3, "SCL and SDA in reset");
        check_value(32'({ready, ack_error}), 32'd0, "o_ready and o_ack_error in reset");
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value(32'({master_scl, master_sda, ack_error}), 32'd6, "lines after reset");
        repeat (2) @(negedge clk);
        check_value(32'(ready), 32'd1, "o_ready after reset");
        for (int i = 0; i < 256; i++) begin
            ref_mem[8'(i)] = u_slave.regs[8'(i)];
        end

        run_request(1'b0, 1'b0, OWN_ADDR, 8'h10, 8'ha5);
        run_request(1'b1, 1'b0, OWN_ADDR, 8'h10, 8'h00);
        // Both enables high, read wins
        run_request(1'b1, 1'b1, OWN_ADDR, 8'hc3, 8'h3c);
        run_request(1'b0, 1'b0, 7'h12, 8'h10, 8'h5a);
        run_request(1'b1, 1'b0, 7'h55, 8'h20, 8'h00);
        check_idle_lines(20);
        run_request(1'b1, 1'b0, OWN_ADDR, 8'hff, 8'h00);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            is_read  = 1'(random_bits(1));
            both     = 1'(random_bits(1));
            reg_addr = 8'(random_bits(8));
            data     = 8'(random_bits(8));
            address  = OWN_ADDR;
            if (random_bits(3) == 32'd0) begin
                address = 7'(random_bits(7));
                if (address == OWN_ADDR) begin
                    address = address ^ 7'h01;
                end
            end
            run_request(is_read, both, address, reg_addr, data);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dv/i2c_slave_model.sv
module i2c_slave_model import i2c_pkg::*; #(
    parameter logic [ADDR_BITS-1:0] OWN_ADDR = 7'h3a
) (
    input  logic i_scl,
    input  logic i_sda,
    output logic o_sda,
    output int   o_start_count,
    output int   o_stop_count
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {
        S_IDLE, S_ADDR, S_ADDR_ACK, S_REG, S_REG_ACK,
        S_WDATA, S_WDATA_ACK, S_RDATA, S_RACK
    } slave_state_e;

    logic [BYTE_BITS-1:0] regs [256];
    slave_state_e         state;
    logic [BYTE_BITS-1:0] shreg;
    logic [BYTE_BITS-1:0] tx_byte;
    logic [BYTE_BITS-1:0] reg_ptr;
    logic                 is_rd;
    logic                 scl_prev;
    logic                 sda_prev;
    int                   bit_cnt;

    // Data bits are taken while SCL is high
    task automatic sample_bit();
        if (state inside {S_ADDR, S_REG, S_WDATA}) begin
            shreg   = {shreg[BYTE_BITS-2:0], i_sda};
            bit_cnt = bit_cnt + 1;
        end else if (state == S_RDATA) begin
            bit_cnt = bit_cnt + 1;
        end
    endtask

    // SDA only changes right after SCL falls
    task automatic drive_bit();
        case (state)
            S_ADDR: begin
                if (bit_cnt == BYTE_BITS) begin
                    bit_cnt = 0;
                    if (shreg[BYTE_BITS-1:1] == OWN_ADDR) begin
                        is_rd = shreg[0];
                        o_sda = 1'b0;
                        state = S_ADDR_ACK;
                    end else begin
                        state = S_IDLE;
                    end
                end
            end
            S_ADDR_ACK: begin
                tx_byte = regs[reg_ptr];
                o_sda   = is_rd ? tx_byte[BYTE_BITS-1] : 1'b1;
                state   = is_rd ? S_RDATA : S_REG;
            end
            S_REG: begin
                if (bit_cnt == BYTE_BITS) begin
                    bit_cnt = 0;
                    reg_ptr = shreg;
                    o_sda   = 1'b0;
                    state   = S_REG_ACK;
                end
            end
            S_REG_ACK: begin
                o_sda = 1'b1;
                state = S_WDATA;
            end
            S_WDATA: begin
                if (bit_cnt == BYTE_BITS) begin
                    bit_cnt       = 0;
                    regs[reg_ptr] = shreg;
                    o_sda         = 1'b0;
                    state         = S_WDATA_ACK;
                end
            end
            S_WDATA_ACK: begin
                o_sda = 1'b1;
                state = S_IDLE;
            end
            S_RDATA: begin
                if (bit_cnt == BYTE_BITS) begin
                    // Master answers the byte with NACK
                    o_sda = 1'b1;
                    state = S_RACK;
                end else begin
                    o_sda = tx_byte[3'(BYTE_BITS - 1 - bit_cnt)];
                end
            end
            default: state = S_IDLE;
        endcase
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            // Odd multiplier so every address bit shows in the data
            regs[8'(i)] = 8'(i * 37 + 8'h5c);
        end
        state         = S_IDLE;
        o_sda         = 1'b1;
        o_start_count = 0;
        o_stop_count  = 0;
        bit_cnt       = 0;
        shreg         = '0;
        tx_byte       = '0;
        reg_ptr       = '0;
        is_rd         = 1'b0;
        scl_prev      = 1'b1;
        sda_prev      = 1'b1;
        forever begin
            @(i_scl or i_sda);
            if (i_scl && scl_prev && sda_prev && !i_sda) begin
                o_start_count = o_start_count + 1;
                bit_cnt       = 0;
                o_sda         = 1'b1;
                state         = S_ADDR;
            end else if (i_scl && scl_prev && !sda_prev && i_sda) begin
                o_stop_count = o_stop_count + 1;
                o_sda        = 1'b1;
                state        = S_IDLE;
            end else if (i_scl && !scl_prev) begin
                sample_bit();
            end else if (!i_scl && scl_prev) begin
                drive_bit();
            end
            scl_prev = i_scl;
            sda_prev = i_sda;
        end
    end

endmodule

// File: hdl/i2c_master.sv
module i2c_master import i2c_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_write_enable,
    input  logic                 i_read_enable,
    input  logic [ADDR_BITS-1:0] i_slave_address,
    input  logic [BYTE_BITS-1:0] i_rw_address,
    input  logic [BYTE_BITS-1:0] i_write_data,
    input  logic                 i_sda,
    output logic [BYTE_BITS-1:0] o_read_data,
    output logic                 o_ready,
    output logic                 o_ack_error,
    output logic                 o_sda,
    output logic                 o_scl
);

    i2c_req_t             req;
    i2c_strobe_t          strobe;
    i2c_sda_sel_e         sda_sel;
    logic                 run;
    logic                 load;
    logic                 shift_out;
    logic                 shift_in;
    logic                 scl_hold;
    logic                 tx_bit;
    logic                 rx_bit;
    logic [BYTE_BITS-1:0] load_byte;
    logic [BYTE_BITS-1:0] shift_byte;

    // Read wins when both enables are high
    assign req.is_read    = i_read_enable;
    assign req.slave_addr = i_slave_address;
    assign req.reg_addr   = i_rw_address;
    assign req.wdata      = i_write_data;

    i2c_sequencer u_sequencer (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_write_enable(i_write_enable), .i_read_enable(i_read_enable), .i_req(req),
        .i_strobe(strobe), .i_rx_bit(rx_bit), .i_shift_byte(shift_byte),
        .o_run(run), .o_load(load), .o_shift_out(shift_out), .o_shift_in(shift_in),
        .o_scl_hold(scl_hold), .o_load_byte(load_byte), .o_sda_sel(sda_sel),
        .o_ready(o_ready), .o_read_data(o_read_data), .o_ack_error(o_ack_error)
    );

    i2c_phase_timer u_timer (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_run(run), .o_strobe(strobe));

    i2c_byte_shifter u_shifter (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_load(load), .i_load_byte(load_byte),
        .i_shift_out(shift_out), .i_shift_in(shift_in), .i_in_bit(rx_bit),
        .o_msb(tx_bit), .o_byte(shift_byte)
    );

    i2c_bus_driver u_bus_driver (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_strobe(strobe), .i_scl_hold(scl_hold),
        .i_sda_sel(sda_sel), .i_tx_bit(tx_bit), .i_sda(i_sda),
        .o_scl(o_scl), .o_sda(o_sda), .o_rx_bit(rx_bit)
    );

endmodule

// File: hdl/i2c_sequencer.sv
module i2c_sequencer import i2c_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_write_enable,
    input  logic                 i_read_enable,
    input  i2c_req_t             i_req,
    input  i2c_strobe_t          i_strobe,
    input  logic                 i_rx_bit,
    input  logic [BYTE_BITS-1:0] i_shift_byte,
    output logic                 o_run,
    output logic                 o_load,
    output logic                 o_shift_out,
    output logic                 o_shift_in,
    output logic                 o_scl_hold,
    output logic [BYTE_BITS-1:0] o_load_byte,
    output i2c_sda_sel_e         o_sda_sel,
    output logic                 o_ready,
    output logic [BYTE_BITS-1:0] o_read_data,
    output logic                 o_ack_error
);

    i2c_phase_e           phase_q;
    i2c_req_t             req_q;
    logic [2:0]           bit_cnt_q;
    logic                 ready_q;
    logic                 ack_error_q;
    logic                 ack_armed_q;
    logic                 rise_q;
    logic                 restart_q;
    logic [BYTE_BITS-1:0] read_data_q;
    logic                 accept;
    logic                 last_bit;
    logic                 shift_phase;
    logic                 ack_phase;
    logic                 ack_check;
    logic                 ack_ok;

    assign accept      = ready_q && (i_write_enable || i_read_enable);
    assign last_bit    = (bit_cnt_q == 3'(BYTE_BITS - 1));
    assign shift_phase = phase_q inside {ADDR, REG, WDATA, RADDR};
    assign ack_phase   = phase_q inside {ADDR_ACK, REG_ACK, WDATA_ACK, RADDR_ACK};
    // rx_bit is valid the cycle after the rise strobe
    assign ack_check   = ack_phase && ack_armed_q && rise_q;
    assign ack_ok      = ack_check && !i_rx_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_q     <= IDLE;
            bit_cnt_q   <= '0;
            ready_q     <= 1'b0;
            ack_error_q <= 1'b0;
            ack_armed_q <= 1'b0;
            rise_q      <= 1'b0;
            restart_q   <= 1'b0;
        end else begin
            rise_q <= i_strobe.scl_rise;
            if ((shift_phase && i_strobe.advance) || o_shift_in) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
            end
            // First rise in an ACK phase still clocks the last data bit
            if (ack_phase && i_strobe.advance) begin
                ack_armed_q <= 1'b1;
            end
            if (ack_check) begin
                ack_armed_q <= 1'b0;
                if (i_rx_bit) begin
                    ack_error_q <= 1'b1;
                    phase_q     <= STOP_PRE;
                end
            end
            case (phase_q)
                IDLE: begin
                    ready_q <= 1'b1;
                    if (accept) begin
                        ready_q     <= 1'b0;
                        ack_error_q <= 1'b0;
                        bit_cnt_q   <= '0;
                        phase_q     <= START;
                    end
                end
                START:         if (i_strobe.advance) phase_q <= ADDR;
                ADDR:          if (i_strobe.advance && last_bit) phase_q <= ADDR_ACK;
                ADDR_ACK:      if (ack_ok) phase_q <= REG;
                REG:           if (i_strobe.advance && last_bit) phase_q <= REG_ACK;
                REG_ACK: begin
                    if (ack_ok) begin
                        phase_q <= req_q.is_read ? RESTART_STOP : WDATA;
                    end
                end
                WDATA:         if (i_strobe.advance && last_bit) phase_q <= WDATA_ACK;
                WDATA_ACK:     if (ack_ok) phase_q <= STOP_PRE;
                RESTART_STOP: begin
                    if (i_strobe.advance) begin
                        restart_q <= 1'b1;
                        phase_q   <= STOP;
                    end
                end
                RESTART_START: if (i_strobe.advance) phase_q <= RADDR;
                RADDR:         if (i_strobe.advance && last_bit) phase_q <= RADDR_ACK;
                RADDR_ACK:     if (ack_ok) phase_q <= RDATA;
                RDATA:         if (o_shift_in && last_bit) phase_q <= RDATA_NACK;
                RDATA_NACK:    if (i_strobe.advance) phase_q <= STOP_PRE;
                STOP_PRE:      if (i_strobe.advance) phase_q <= STOP;
                STOP: begin
                    if (i_strobe.advance) begin
                        // Stop of the register-address half is followed by a new start
                        restart_q <= 1'b0;
                        if (restart_q) begin
                            phase_q <= RESTART_START;
                        end else begin
                            phase_q <= IDLE;
                            ready_q <= 1'b1;
                        end
                    end
                end
                default:       phase_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_q <= i_req;
        end
        if (phase_q == RDATA_NACK && i_strobe.advance) begin
            read_data_q <= i_shift_byte;
        end
    end

    always_comb begin
        case (phase_q)
            ADDR_ACK:      o_load_byte = req_q.reg_addr;
            REG_ACK:       o_load_byte = req_q.wdata;
            RESTART_START: o_load_byte = {req_q.slave_addr, RW_READ};
            default:       o_load_byte = {req_q.slave_addr, RW_WRITE};
        endcase
    end

    always_comb begin
        case (phase_q)
            START, RESTART_START, RESTART_STOP, STOP_PRE: o_sda_sel = LOW;
            ADDR, REG, WDATA, RADDR:                      o_sda_sel = SHIFT;
            default:                                      o_sda_sel = RELEASE;
        endcase
    end

    // Next byte is loaded ahead of the advance that sends its MSB
    assign o_load = (i_strobe.advance && (phase_q == START || phase_q == RESTART_START))
                 || (ack_ok && (phase_q == ADDR_ACK || phase_q == REG_ACK));

    assign o_run       = (phase_q != IDLE);
    assign o_shift_out = shift_phase && i_strobe.advance;
    assign o_shift_in  = (phase_q == RDATA) && rise_q;
    assign o_scl_hold  = phase_q inside {START, RESTART_START, STOP};
    assign o_ready     = ready_q;
    assign o_read_data = read_data_q;
    assign o_ack_error = ack_error_q;

endmodule

// File: hdl/i2c_bus_driver.sv
module i2c_bus_driver import i2c_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  i2c_strobe_t  i_strobe,
    input  logic         i_scl_hold,
    input  i2c_sda_sel_e i_sda_sel,
    input  logic         i_tx_bit,
    input  logic         i_sda,
    output logic         o_scl,
    output logic         o_sda,
    output logic         o_rx_bit
);

    logic scl_q;
    logic sda_q;
    logic rx_bit_q;

    // Open-drain enables, 1 lets the pull-up win
    assign o_scl    = scl_q;
    assign o_sda    = sda_q;
    assign o_rx_bit = rx_bit_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
        end else begin
            if (i_strobe.advance) begin
                case (i_sda_sel)
                    LOW:     sda_q <= 1'b0;
                    SHIFT:   sda_q <= i_tx_bit;
                    default: sda_q <= 1'b1;
                endcase
            end
            // SCL stays high around start and stop conditions
            if (i_strobe.scl_fall && !i_scl_hold) begin
                scl_q <= 1'b0;
            end
            if (i_strobe.scl_rise) begin
                scl_q <= 1'b1;
            end
        end
    end

    // Line level at SCL rise, used for ACK and read data alike
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_bit_q <= 1'b1;
        end else if (i_strobe.scl_rise) begin
            rx_bit_q <= i_sda;
        end
    end

endmodule

// File: hdl/i2c_byte_shifter.sv
module i2c_byte_shifter import i2c_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_load,
    input  logic [BYTE_BITS-1:0] i_load_byte,
    input  logic                 i_shift_out,
    input  logic                 i_shift_in,
    input  logic                 i_in_bit,
    output logic                 o_msb,
    output logic [BYTE_BITS-1:0] o_byte
);

    logic [BYTE_BITS-1:0] shift_q;
    logic                 lsb_in;

    // Zero fills behind transmitted bits, sampled bit fills on receive
    assign lsb_in = i_shift_in ? i_in_bit : 1'b0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shift_q <= '0;
        end else if (i_load) begin
            shift_q <= i_load_byte;
        end else if (i_shift_out || i_shift_in) begin
            // MSB first in both directions
            shift_q <= {shift_q[BYTE_BITS-2:0], lsb_in};
        end
    end

    // Bit that goes onto SDA at the next advance
    assign o_msb  = shift_q[BYTE_BITS-1];

    // Whole byte, read data after eight shift-ins
    assign o_byte = shift_q;

endmodule

// File: hdl/i2c_phase_timer.sv
module i2c_phase_timer import i2c_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_run,
    output i2c_strobe_t o_strobe
);

    logic [PHASE_WIDTH-1:0] acc_q;
    logic [1:0]             top_prev_q;
    logic [1:0]             top_bits;
    logic [3:0]             edge_bits;
    i2c_strobe_t            strobe_q;

    // Top two bits split each bit period into quarters
    assign top_bits  = acc_q[PHASE_WIDTH-1 -: 2];
    assign edge_bits = {top_prev_q, top_bits};
    assign o_strobe  = strobe_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_q      <= '0;
            top_prev_q <= 2'b00;
        end else if (!i_run) begin
            // Held at zero so every transaction starts on the same phase
            acc_q      <= '0;
            top_prev_q <= 2'b00;
        end else begin
            acc_q      <= acc_q + PHASE_INCR;
            top_prev_q <= top_bits;
        end
    end

    // One pulse per quarter transition of interest
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            strobe_q <= '0;
        end else begin
            strobe_q.scl_rise <= i_run && (edge_bits == 4'b0001);
            strobe_q.scl_fall <= i_run && (edge_bits == 4'b1011);
            // Wrap back to zero lands in the middle of SCL low
            strobe_q.advance  <= i_run && (edge_bits == 4'b1100);
        end
    end

endmodule

// File: hdl/i2c_pkg.sv
package i2c_pkg;

    // Bus timing
    localparam int CLOCK_HZ    = 20_000_000;
    localparam int BUS_HZ      = 1_000_000;
    localparam int PHASE_WIDTH = 25;

    // Step per clock so that the accumulator wraps once per bit
    localparam longint PHASE_SCALE = longint'(1) << PHASE_WIDTH;
    localparam logic [PHASE_WIDTH-1:0] PHASE_INCR =
        PHASE_WIDTH'(PHASE_SCALE * BUS_HZ / CLOCK_HZ);

    localparam int ADDR_BITS = 7;
    localparam int BYTE_BITS = 8;

    // Direction bit appended to the slave address
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    typedef enum logic [4:0] {
        IDLE,
        START,
        ADDR,
        ADDR_ACK,
        REG,
        REG_ACK,
        WDATA,
        WDATA_ACK,
        RESTART_STOP,
        RESTART_START,
        RADDR,
        RADDR_ACK,
        RDATA,
        RDATA_NACK,
        STOP_PRE,
        STOP
    } i2c_phase_e;

    typedef struct packed {
        logic                 is_read;
        logic [ADDR_BITS-1:0] slave_addr;
        logic [BYTE_BITS-1:0] reg_addr;
        logic [BYTE_BITS-1:0] wdata;
    } i2c_req_t;

    typedef struct packed {
        logic advance;
        logic scl_rise;
        logic scl_fall;
    } i2c_strobe_t;

    // SDA source applied on each advance strobe
    typedef enum logic [1:0] {
        RELEASE,
        LOW,
        SHIFT
    } i2c_sda_sel_e;

endpackage
